// ==== hdl/hpm_pkg.sv ====
// Performance monitor package: bus and counter widths, event indices, APB address map
`default_nettype none

package hpm_pkg;

    // Bus and counter widths
    localparam int APB_ADDR_W = 12;
    localparam int APB_DATA_W = 32;
    localparam int HPM_CNT_W  = 64;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;
    typedef logic [HPM_CNT_W-1:0]  hpm_cnt_t;

    // Event sources, index 0 means the counter is off
    localparam int HPM_NUM_EVENTS = 21;
    localparam int HPM_EVSEL_W    = 5;

    typedef logic [HPM_EVSEL_W-1:0]  hpm_evsel_t;
    typedef logic [HPM_NUM_EVENTS:0] hpm_event_vec_t;

    // Event indices as seen on events_i
    localparam hpm_evsel_t EV_BRANCH_MISS      = 5'd1;
    localparam hpm_evsel_t EV_IS_BRANCH        = 5'd2;
    localparam hpm_evsel_t EV_BRANCH_TAKEN     = 5'd3;
    localparam hpm_evsel_t EV_EXE_STORE        = 5'd4;
    localparam hpm_evsel_t EV_EXE_LOAD         = 5'd5;
    localparam hpm_evsel_t EV_ICACHE_REQ       = 5'd6;
    localparam hpm_evsel_t EV_ICACHE_KILL      = 5'd7;
    localparam hpm_evsel_t EV_STALL_IF         = 5'd8;
    localparam hpm_evsel_t EV_STALL_ID         = 5'd9;
    localparam hpm_evsel_t EV_STALL_RR         = 5'd10;
    localparam hpm_evsel_t EV_STALL_EXE        = 5'd11;
    localparam hpm_evsel_t EV_STALL_WB         = 5'd12;
    localparam hpm_evsel_t EV_BUFFER_MISS      = 5'd13;
    localparam hpm_evsel_t EV_IMISS_KILL       = 5'd14;
    localparam hpm_evsel_t EV_ICACHE_BUSY      = 5'd15;
    localparam hpm_evsel_t EV_IMISS_TIME       = 5'd16;
    localparam hpm_evsel_t EV_LOAD_STORE       = 5'd17;
    localparam hpm_evsel_t EV_DATA_DEPEND      = 5'd18;
    localparam hpm_evsel_t EV_STRUCT_DEPEND    = 5'd19;
    localparam hpm_evsel_t EV_GRAD_LIST_FULL   = 5'd20;
    localparam hpm_evsel_t EV_FREE_LIST_EMPTY  = 5'd21;

    // Address map, byte addresses
    localparam apb_addr_t HPM_EVSEL_BASE   = 12'h000;
    localparam apb_addr_t HPM_CNT_BASE     = 12'h100;
    localparam int        HPM_MAX_COUNTERS = 32;
    localparam int        HPM_IDX_W        = $clog2(HPM_MAX_COUNTERS);

endpackage

`default_nettype wire

// ==== hdl/hpm_apb_slave.sv ====
// APB slave for the performance monitor: address decode, write strobe, read data and slave error
`timescale 1ns/100ps
`default_nettype none

module hpm_apb_slave #(
    parameter int NUM_COUNTERS = 8
) (
    // APB slave port
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  hpm_pkg::apb_addr_t            paddr_i,
    input  hpm_pkg::apb_data_t            pwdata_i,
    output hpm_pkg::apb_data_t            prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,

    // Register bank access
    output logic                          reg_we_o,
    output logic                          reg_sel_evsel_o,
    output logic                          reg_sel_cnt_o,
    output logic                          reg_hi_o,
    output logic [hpm_pkg::HPM_IDX_W-1:0] reg_idx_o,
    output hpm_pkg::apb_data_t            reg_wdata_o,
    input  hpm_pkg::apb_data_t            reg_rdata_i
);

    import hpm_pkg::*;

    apb_addr_t evsel_off;
    apb_addr_t cnt_off;
    logic      aligned;
    logic      evsel_hit;
    logic      cnt_hit;
    logic      mapped;
    logic      access;

    // Offsets into each region
    // An address below a base wraps to a large offset and misses the region
    assign evsel_off = paddr_i - HPM_EVSEL_BASE;
    assign cnt_off   = paddr_i - HPM_CNT_BASE;

    assign aligned = (paddr_i[1:0] == 2'b00);

    // One 32-bit word per selector
    assign evsel_hit = aligned && (int'(evsel_off[APB_ADDR_W-1:2]) < NUM_COUNTERS);

    // Two words per counter, low half first
    assign cnt_hit = aligned && (int'(cnt_off[APB_ADDR_W-1:3]) < NUM_COUNTERS);

    // Selector and counter regions never overlap
    assign reg_sel_evsel_o = evsel_hit;
    assign reg_sel_cnt_o   = cnt_hit;
    assign mapped          = reg_sel_evsel_o || reg_sel_cnt_o;

    assign reg_hi_o = reg_sel_cnt_o && cnt_off[2];

    always_comb begin
        reg_idx_o = '0;
        if (reg_sel_evsel_o) begin
            reg_idx_o = evsel_off[HPM_IDX_W+1:2];
        end else if (reg_sel_cnt_o) begin
            reg_idx_o = cnt_off[HPM_IDX_W+2:3];
        end
    end

    // Second cycle of the transfer
    assign access = psel_i && penable_i;

    assign reg_we_o    = access && pwrite_i && mapped;
    assign reg_wdata_o = pwdata_i;

    // Read data only for a mapped read, zero otherwise
    always_comb begin
        prdata_o = '0;
        if (access && !pwrite_i && mapped) begin
            prdata_o = reg_rdata_i;
        end
    end

    assign pslverr_o = access && !mapped;

    // No wait states
    assign pready_o = 1'b1;

endmodule

`default_nettype wire

// ==== hdl/hpm_event_sel.sv ====
// Event multiplexer: one selected event strobe per performance counter
`timescale 1ns/100ps
`default_nettype none

module hpm_event_sel #(
    parameter int NUM_COUNTERS = 8
) (
    input  hpm_pkg::hpm_evsel_t [NUM_COUNTERS-1:0] evsel_i,
    input  hpm_pkg::hpm_event_vec_t                events_i,
    output logic [NUM_COUNTERS-1:0]                hit_o
);

    import hpm_pkg::*;

    // Every selector value has an entry
    localparam int TABLE_W = 2 ** HPM_EVSEL_W;

    logic [TABLE_W-1:0] ev_table;

    // Entry 0 is the "off" selector and stays low
    // Entries above the last event source are also low
    assign ev_table = {
        {(TABLE_W-HPM_NUM_EVENTS-1){1'b0}},
        events_i[HPM_NUM_EVENTS:1],
        1'b0
    };

    always_comb begin
        for (int i = 0; i < NUM_COUNTERS; i++) begin
            hit_o[i] = ev_table[evsel_i[i]];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/hpm_counters.sv ====
// Counter bank: event selectors, 64-bit counters, increment and 32-bit half access
`timescale 1ns/100ps
`default_nettype none

module hpm_counters #(
    parameter int NUM_COUNTERS = 8
) (
    input  logic                                   clk_i,
    input  logic                                   rstn_i,

    // Register access from the APB slave
    input  logic                                   reg_we_i,
    input  logic                                   reg_sel_evsel_i,
    input  logic                                   reg_sel_cnt_i,
    input  logic                                   reg_hi_i,
    input  logic [hpm_pkg::HPM_IDX_W-1:0]          reg_idx_i,
    input  hpm_pkg::apb_data_t                     reg_wdata_i,
    output hpm_pkg::apb_data_t                     reg_rdata_o,

    // Event selection
    output hpm_pkg::hpm_evsel_t [NUM_COUNTERS-1:0] evsel_o,
    input  logic [NUM_COUNTERS-1:0]                hit_i
);

    import hpm_pkg::*;

    hpm_evsel_t [NUM_COUNTERS-1:0] evsel_q;
    hpm_cnt_t                      cnt_q [NUM_COUNTERS];

    logic [NUM_COUNTERS-1:0]       evsel_wr;
    logic [NUM_COUNTERS-1:0]       cnt_wr;

    hpm_evsel_t                    rd_evsel;
    hpm_cnt_t                      rd_cnt;

    // Per-counter write enables
    always_comb begin
        for (int i = 0; i < NUM_COUNTERS; i++) begin
            evsel_wr[i] = reg_we_i && reg_sel_evsel_i && (int'(reg_idx_i) == i);
            cnt_wr[i]   = reg_we_i && reg_sel_cnt_i && (int'(reg_idx_i) == i);
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            evsel_q <= '0;
            cnt_q   <= '{default: '0};
        end else begin
            for (int i = 0; i < NUM_COUNTERS; i++) begin
                if (evsel_wr[i]) begin
                    evsel_q[i] <= reg_wdata_i[HPM_EVSEL_W-1:0];
                end

                // Selector 0 holds the counter at zero
                // A half write replaces the increment on that edge
                if (evsel_q[i] == '0) begin
                    cnt_q[i] <= '0;
                end else if (cnt_wr[i]) begin
                    if (reg_hi_i) begin
                        cnt_q[i][HPM_CNT_W-1:APB_DATA_W] <= reg_wdata_i;
                    end else begin
                        cnt_q[i][APB_DATA_W-1:0] <= reg_wdata_i;
                    end
                end else begin
                    cnt_q[i] <= cnt_q[i] + hpm_cnt_t'(hit_i[i]);
                end
            end
        end
    end

    assign evsel_o = evsel_q;

    // Addressed selector and counter
    always_comb begin
        rd_evsel = '0;
        rd_cnt   = '0;
        for (int i = 0; i < NUM_COUNTERS; i++) begin
            if (int'(reg_idx_i) == i) begin
                rd_evsel = evsel_q[i];
                rd_cnt   = cnt_q[i];
            end
        end
    end

    // Selector reads back zero-extended
    always_comb begin
        reg_rdata_o = '0;
        if (reg_sel_evsel_i) begin
            reg_rdata_o = apb_data_t'(rd_evsel);
        end else if (reg_sel_cnt_i) begin
            if (reg_hi_i) begin
                reg_rdata_o = rd_cnt[HPM_CNT_W-1:APB_DATA_W];
            end else begin
                reg_rdata_o = rd_cnt[APB_DATA_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/hpm_top.sv ====
// Performance monitor top level: APB slave, counter bank and event multiplexer
`timescale 1ns/100ps
`default_nettype none

module hpm_top #(
    parameter int NUM_COUNTERS = 8
) (
    input  logic                    clk_i,
    input  logic                    rstn_i,

    // APB slave port
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  hpm_pkg::apb_addr_t      paddr_i,
    input  hpm_pkg::apb_data_t      pwdata_i,
    output hpm_pkg::apb_data_t      prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,

    // Single-cycle event strobes from the core
    input  hpm_pkg::hpm_event_vec_t events_i
);

    import hpm_pkg::*;

    logic                          reg_we;
    logic                          reg_sel_evsel;
    logic                          reg_sel_cnt;
    logic                          reg_hi;
    logic [HPM_IDX_W-1:0]          reg_idx;
    apb_data_t                     reg_wdata;
    apb_data_t                     reg_rdata;

    hpm_evsel_t [NUM_COUNTERS-1:0] evsel;
    logic [NUM_COUNTERS-1:0]       hit;

    hpm_apb_slave #(
        .NUM_COUNTERS    (NUM_COUNTERS)
    ) u_apb_slave (
        .psel_i          (psel_i),
        .penable_i       (penable_i),
        .pwrite_i        (pwrite_i),
        .paddr_i         (paddr_i),
        .pwdata_i        (pwdata_i),
        .prdata_o        (prdata_o),
        .pready_o        (pready_o),
        .pslverr_o       (pslverr_o),
        .reg_we_o        (reg_we),
        .reg_sel_evsel_o (reg_sel_evsel),
        .reg_sel_cnt_o   (reg_sel_cnt),
        .reg_hi_o        (reg_hi),
        .reg_idx_o       (reg_idx),
        .reg_wdata_o     (reg_wdata),
        .reg_rdata_i     (reg_rdata)
    );

    hpm_counters #(
        .NUM_COUNTERS    (NUM_COUNTERS)
    ) u_counters (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .reg_we_i        (reg_we),
        .reg_sel_evsel_i (reg_sel_evsel),
        .reg_sel_cnt_i   (reg_sel_cnt),
        .reg_hi_i        (reg_hi),
        .reg_idx_i       (reg_idx),
        .reg_wdata_i     (reg_wdata),
        .reg_rdata_o     (reg_rdata),
        .evsel_o         (evsel),
        .hit_i           (hit)
    );

    hpm_event_sel #(
        .NUM_COUNTERS    (NUM_COUNTERS)
    ) u_event_sel (
        .evsel_i         (evsel),
        .events_i        (events_i),
        .hit_o           (hit)
    );

endmodule

`default_nettype wire

// ==== tb/hpm_sva.sv ====
// Concurrent assertions on the APB response of hpm_top
`timescale 1ns/100ps
`default_nettype none

module hpm_sva (
    input logic               clk_i,
    input logic               rstn_i,
    input logic               psel_i,
    input logic               penable_i,
    input logic               pready_i,
    input logic               pslverr_i,
    input hpm_pkg::apb_data_t prdata_i
);

    logic access;

    assign access = psel_i && penable_i;

    // No wait states
    a_ready_in_access: assert property (@(posedge clk_i) disable iff (!rstn_i)
        access |-> pready_i)
        else $error("pready_o low in an access cycle");

    a_no_err_outside_access: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !access |-> !pslverr_i)
        else $error("pslverr_o high outside an access cycle");

    a_zero_data_on_err: assert property (@(posedge clk_i) disable iff (!rstn_i)
        pslverr_i |-> (prdata_i == '0))
        else $error("prdata_o not zero with pslverr_o high");

endmodule

bind hpm_top hpm_sva u_sva (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pready_i  (pready_o),
    .pslverr_i (pslverr_o),
    .prdata_i  (prdata_o)
);

`default_nettype wire

// ==== tb/tb_hpm.sv ====
// Testbench for hpm_top: clock, reset, LFSR stimulus, APB tasks, reference model and watchdog
`timescale 1ns/100ps
`default_nettype none

module tb_hpm;

    import hpm_pkg::*;

    localparam int          NUM_CNT         = 8;
    localparam int          CLK_PERIOD      = 10;
    localparam logic [31:0] LFSR_SEED       = 32'hd2a4;
    localparam logic [31:0] LFSR_TAPS       = 32'h80200003;
    localparam int          SEL_ZERO_EVENTS = 20;
    localparam int          ROUNDS          = 4;
    localparam int          EV_CYCLES       = 100;
    localparam int          CARRY_CYCLES    = 40;
    localparam int          UNMAPPED_N      = 40;

    // Cycle budget of all tests, used by the watchdog
    localparam int CHECK_CYCLES   = NUM_CNT * 3 * 2;
    localparam int PLANNED_CYCLES = 3 + CHECK_CYCLES
        + (NUM_CNT * 4 + 8 + SEL_ZERO_EVENTS + CHECK_CYCLES)
        + ROUNDS * (NUM_CNT * 2 + EV_CYCLES + CHECK_CYCLES)
        + (NUM_CNT * 12 + CARRY_CYCLES + CHECK_CYCLES + 6)
        + (UNMAPPED_N * 4 + CHECK_CYCLES);

    logic           clk;
    logic           rstn;
    logic           psel;
    logic           penable;
    logic           pwrite;
    apb_addr_t      paddr;
    apb_data_t      pwdata;
    apb_data_t      prdata;
    logic           pready;
    logic           pslverr;
    hpm_event_vec_t events;

    logic [31:0]    lfsr_state;
    int             data_errs;
    int             slverr_errs;
    int             other_errs;

    // Reference model state
    hpm_cnt_t       model_cnt [NUM_CNT];
    hpm_evsel_t     model_sel [NUM_CNT];

    hpm_top #(
        .NUM_COUNTERS (NUM_CNT)
    ) u_dut (
        .clk_i     (clk),
        .rstn_i    (rstn),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .events_i  (events)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    // Address map: kind 0 unmapped, 1 selector, 2 counter half
    function automatic void decode_addr(input apb_addr_t a, output int kind, output int idx,
                                        output logic hi);
        apb_addr_t sel_off;
        apb_addr_t cnt_off;
        kind    = 0;
        idx     = 0;
        hi      = 1'b0;
        sel_off = a - HPM_EVSEL_BASE;
        cnt_off = a - HPM_CNT_BASE;
        if (a[1:0] != 2'b00) begin
            return;
        end
        if (int'(sel_off) < 4 * NUM_CNT) begin
            kind = 1;
            idx  = int'(sel_off) / 4;
        end else if (int'(cnt_off) < 8 * NUM_CNT) begin
            kind = 2;
            idx  = int'(cnt_off) / 8;
            hi   = cnt_off[2];
        end
    endfunction

    function automatic apb_data_t expected_read(input apb_addr_t a);
        int   kind;
        int   idx;
        logic hi;
        decode_addr(a, kind, idx, hi);
        if (kind == 1) begin
            return apb_data_t'(model_sel[idx]);
        end else if (kind == 2) begin
            return hi ? model_cnt[idx][63:32] : model_cnt[idx][31:0];
        end
        return '0;
    endfunction

    function automatic logic is_unmapped(input apb_addr_t a);
        int   kind;
        int   idx;
        logic hi;
        decode_addr(a, kind, idx, hi);
        return (kind == 0);
    endfunction

    function automatic apb_addr_t sel_addr(input int i);
        return HPM_EVSEL_BASE + apb_addr_t'(4 * i);
    endfunction

    function automatic apb_addr_t cnt_addr(input int i, input logic hi);
        return HPM_CNT_BASE + apb_addr_t'(8 * i) + (hi ? 12'h004 : 12'h000);
    endfunction

    // Gaps, counters beyond the bank, and misaligned words
    function automatic apb_addr_t unmapped_addr();
        logic [31:0] kind;
        logic [31:0] r;
        kind = rand_bits(2);
        case (kind[1:0])
            2'd0: begin
                r = rand_bits(5);
                return 12'h020 + apb_addr_t'(r << 2);
            end
            2'd1: begin
                r = rand_bits(8);
                return 12'h140 + apb_addr_t'(r << 2);
            end
            2'd2: begin
                r = rand_bits(10);
                kind = rand_bits(2);
                return apb_addr_t'(r << 2) | apb_addr_t'(kind % 3 + 1);
            end
            default: begin
                r = rand_bits(6);
                return 12'hF00 + apb_addr_t'(r << 2);
            end
        endcase
    endfunction

    // Same update rules as the counter bank, applied at each edge
    always @(posedge clk or negedge rstn) begin : model_update
        int         kind;
        int         idx;
        logic       hi;
        logic       wr;
        hpm_evsel_t sel_old;
        if (!rstn) begin
            for (int i = 0; i < NUM_CNT; i++) begin
                model_cnt[i] = '0;
                model_sel[i] = '0;
            end
        end else begin
            decode_addr(paddr, kind, idx, hi);
            wr = psel && penable && pwrite && (kind != 0);
            for (int i = 0; i < NUM_CNT; i++) begin
                sel_old = model_sel[i];
                if (sel_old == '0) begin
                    model_cnt[i] = '0;
                end else if (wr && kind == 2 && idx == i) begin
                    if (hi) begin
                        model_cnt[i][63:32] = pwdata;
                    end else begin
                        model_cnt[i][31:0] = pwdata;
                    end
                end else if (int'(sel_old) <= HPM_NUM_EVENTS && events[sel_old]) begin
                    model_cnt[i] = model_cnt[i] + 64'd1;
                end
                if (wr && kind == 1 && idx == i) begin
                    model_sel[i] = pwdata[4:0];
                end
            end
        end
    end

    task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
        if (got !== exp) begin
            data_errs++;
            $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            slverr_errs++;
            $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_ready();
        if (pready !== 1'b1) begin
            other_errs++;
            $display("pready_o was not high during an APB access cycle at %0t", $time);
        end
    endtask

    // Both tasks start and end 1 ns after a rising edge
    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #4;
        check_ready();
        check_err("pslverr_o", pslverr, is_unmapped(addr));
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #4;
        check_ready();
        check_data("prdata_o", prdata, expected_read(addr));
        check_err("pslverr_o", pslverr, is_unmapped(addr));
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_all();
        for (int i = 0; i < NUM_CNT; i++) begin
            apb_read(sel_addr(i));
            apb_read(cnt_addr(i, 1'b0));
            apb_read(cnt_addr(i, 1'b1));
        end
    endtask

    // Random or all-high event strobes, bit 0 included, then back to zero
    task automatic run_events(input int cycles, input logic all_high);
        logic [31:0] r;
        for (int c = 0; c < cycles; c++) begin
            r = rand_bits(HPM_NUM_EVENTS + 1);
            events = all_high ? {(HPM_NUM_EVENTS + 1){1'b1}} : r[HPM_NUM_EVENTS:0];
            @(posedge clk);
            #1;
        end
        events = '0;
    endtask

    initial begin : watchdog
        #(20 * PLANNED_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("Testbench failed");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] r;
        clk         = 1'b0;
        rstn        = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        events      = '0;
        lfsr_state  = LFSR_SEED;
        data_errs   = 0;
        slverr_errs = 0;
        other_errs  = 0;
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;

        // Reset values
        check_data("prdata_o", prdata, '0);
        check_err("pslverr_o", pslverr, 1'b0);
        read_all();

        // Selector readback, counters 0 and 1 switched off
        for (int i = 0; i < NUM_CNT; i++) begin
            r = rand_bits(32);
            if (i < 2) begin
                r[4:0] = 5'd0;
            end
            apb_write(sel_addr(i), r);
            apb_read(sel_addr(i));
        end
        run_events(SEL_ZERO_EVENTS, 1'b0);
        read_all();

        // Random counting
        for (int k = 0; k < ROUNDS; k++) begin
            for (int i = 0; i < NUM_CNT; i++) begin
                r = rand_bits(5);
                apb_write(sel_addr(i), r % 21 + 1);
            end
            run_events(EV_CYCLES, 1'b0);
            read_all();
        end

        // Half writes and carry into the high half
        for (int i = 0; i < NUM_CNT; i++) begin
            apb_write(cnt_addr(i, 1'b1), rand_bits(32));
            apb_read(cnt_addr(i, 1'b0));
            apb_read(cnt_addr(i, 1'b1));
            apb_write(cnt_addr(i, 1'b0), 32'hFFFF_FFF0 | rand_bits(4));
            apb_read(cnt_addr(i, 1'b0));
            apb_read(cnt_addr(i, 1'b1));
        end
        run_events(CARRY_CYCLES, 1'b1);
        read_all();

        // Switching a running counter off clears it
        apb_write(sel_addr(0), 32'd0);
        apb_read(cnt_addr(0, 1'b0));
        apb_read(cnt_addr(0, 1'b1));

        // Unmapped accesses
        for (int n = 0; n < UNMAPPED_N; n++) begin
            paddr = unmapped_addr();
            apb_write(paddr, rand_bits(32));
            apb_read(paddr);
        end
        read_all();

        $display("Errors: data %0d, slverr %0d, other %0d", data_errs, slverr_errs, other_errs);
        if (data_errs + slverr_errs + other_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/hpm_pkg.sv
hdl/hpm_apb_slave.sv
hdl/hpm_event_sel.sv
hdl/hpm_counters.sv
hdl/hpm_top.sv
tb/hpm_sva.sv
tb/tb_hpm.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the performance monitor testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_hpm -o Vtb_hpm

./obj_dir/Vtb_hpm 2>&1 | tee "$LOG"

if grep -q "Testbench failed" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi

if ! grep -q "Testbench passed" "$LOG"; then
    echo "Simulation did not complete"
    exit 1
fi

echo "Simulation PASSED"
